// File: include/sram_defs.svh
`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// data word carried by both bus ports and both chips
`define SRAM_WORD_W 32

// byte lanes per word, one select bit each
`define SRAM_SEL_W 4

// address width inside one chip
`define SRAM_CHIP_AW 20

// bus word address, one bit wider than a chip address
// the extra low bit picks the bank (0 = base, 1 = ext)
`define SRAM_BUS_AW 21

`endif

// File: verilog/sram_pkg.sv
`include "sram_defs.svh"

package sram_pkg;

    typedef logic [`SRAM_WORD_W-1:0]  word_t;
    typedef logic [`SRAM_SEL_W-1:0]   byte_sel_t;   // active high on the bus side
    typedef logic [`SRAM_BUS_AW-1:0]  bus_addr_t;
    typedef logic [`SRAM_CHIP_AW-1:0] chip_addr_t;

    // which port owns the current scheduler slot
    typedef enum logic {
        SLOT_INST = 1'b0,
        SLOT_DATA = 1'b1
    } slot_t;

    // request from a port to the scheduler, held until done
    typedef struct packed {
        logic       valid;
        logic       write;
        byte_sel_t  sel;
        logic       base_en;
        logic       ext_en;
        chip_addr_t base_addr;
        chip_addr_t ext_addr;
        word_t      wdata;
    } sram_req_t;

    typedef struct packed {
        logic  done;        // one cycle pulse
        word_t base_rdata;
        word_t ext_rdata;
    } sram_rsp_t;

    // outputs toward one chip, the data bus split into out and drive
    typedef struct packed {
        logic       ce_n;
        logic       oe_n;
        logic       we_n;
        byte_sel_t  be_n;
        chip_addr_t addr;
        word_t      data_out;
        logic       drive;
    } sram_pins_t;

endpackage

// File: verilog/inst_fetch_port.sv
`timescale 1ns/1ps

module inst_fetch_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  sram_pkg::bus_addr_t adr,
    input  sram_pkg::sram_rsp_t rsp,
    output logic               ack,
    output sram_pkg::word_t    dat,
    output sram_pkg::word_t    dat2,
    output sram_pkg::sram_req_t req
);

    logic                 valid_q;
    logic                 odd_q;       // parity of the fetched address
    sram_pkg::chip_addr_t base_addr_q;
    sram_pkg::chip_addr_t ext_addr_q;
    sram_pkg::chip_addr_t half_addr;
    logic                 accept;

    assign half_addr = sram_pkg::chip_addr_t'(adr >> 1);

    // no new request in the ack cycle or while one is outstanding
    assign accept = cyc && stb && !ack && !valid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            ack     <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (accept) begin
                valid_q <= 1'b1;
            end else if (valid_q && rsp.done) begin
                valid_q <= 1'b0;
                ack     <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            odd_q     <= adr[0];
            ext_addr_q <= half_addr;
            // odd start: word adr+1 sits one row higher in the base bank
            base_addr_q <= adr[0] ? half_addr + 1'b1 : half_addr;
        end
        if (valid_q && rsp.done) begin
            dat  <= odd_q ? rsp.ext_rdata : rsp.base_rdata;
            dat2 <= odd_q ? rsp.base_rdata : rsp.ext_rdata;
        end
    end

    // fetches always read a word from each bank
    assign req = '{
        valid:     valid_q,
        write:     1'b0,
        sel:       '1,
        base_en:   1'b1,
        ext_en:    1'b1,
        base_addr: base_addr_q,
        ext_addr:  ext_addr_q,
        wdata:     '0
    };

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("instruction ack held for more than one cycle");

endmodule

// File: verilog/data_access_port.sv
`timescale 1ns/1ps

module data_access_port (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  sram_pkg::byte_sel_t  sel,
    input  sram_pkg::bus_addr_t  adr,
    input  sram_pkg::word_t      dat_w,
    input  sram_pkg::sram_rsp_t  rsp,
    output logic                 ack,
    output sram_pkg::word_t      dat_r,
    output sram_pkg::sram_req_t  req
);

    logic                 valid_q;
    logic                 write_q;
    logic                 odd_q;       // bank of the access, 1 = ext
    sram_pkg::byte_sel_t  sel_q;
    sram_pkg::chip_addr_t addr_q;
    sram_pkg::word_t      wdata_q;
    logic                 accept;
    logic                 finish;

    assign accept = cyc && stb && !ack && !valid_q;
    assign finish = valid_q && rsp.done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            ack     <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (accept) begin
                valid_q <= 1'b1;
            end else if (finish) begin
                valid_q <= 1'b0;
                ack     <= 1'b1;
            end
        end
    end

    // request fields are sampled once, at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            write_q <= we;
            sel_q   <= sel;
            odd_q   <= adr[0];
            addr_q  <= sram_pkg::chip_addr_t'(adr >> 1);
            wdata_q <= dat_w;
        end
    end

    // writes leave the last read word in place
    always_ff @(posedge clk) begin
        if (finish && !write_q) begin
            dat_r <= odd_q ? rsp.ext_rdata : rsp.base_rdata;
        end
    end

    assign req = '{
        valid:     valid_q,
        write:     write_q,
        sel:       sel_q,
        base_en:   !odd_q,
        ext_en:    odd_q,
        base_addr: addr_q,      // only the enabled bank looks at its address
        ext_addr:  addr_q,
        wdata:     wdata_q
    };

    ack_inside_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> cyc)
        else $error("data ack raised outside a bus cycle");

endmodule

// File: verilog/sram_bank_scheduler.sv
`timescale 1ns/1ps

module sram_bank_scheduler (
    input  logic                 clk,
    input  logic                 rst,
    input  sram_pkg::sram_req_t  inst_req,
    input  sram_pkg::sram_req_t  data_req,
    output sram_pkg::sram_rsp_t  inst_rsp,
    output sram_pkg::sram_rsp_t  data_rsp,
    input  sram_pkg::word_t      base_data_in,
    input  sram_pkg::word_t      ext_data_in,
    output sram_pkg::sram_pins_t base_pins,
    output sram_pkg::sram_pins_t ext_pins
);

    localparam sram_pkg::sram_pins_t idle_pins = '{
        ce_n:     1'b1,
        oe_n:     1'b1,
        we_n:     1'b1,
        be_n:     '1,
        addr:     '0,
        data_out: '0,
        drive:    1'b0
    };

    sram_pkg::slot_t      slot;
    logic                 busy;        // access cycle on the pins
    sram_pkg::slot_t      owner;       // port of that access
    logic                 done_q;
    sram_pkg::slot_t      done_owner;
    sram_pkg::word_t      base_rdata_q;
    sram_pkg::word_t      ext_rdata_q;
    sram_pkg::sram_pins_t base_q;
    sram_pkg::sram_pins_t ext_q;
    sram_pkg::sram_req_t  cur_req;
    logic                 in_flight;
    logic                 grant;

    // build the next pin state of one bank, idle unless it takes part
    function automatic sram_pkg::sram_pins_t next_pins(
        input logic                 take,
        input sram_pkg::sram_req_t  r,
        input sram_pkg::chip_addr_t a,
        input sram_pkg::sram_pins_t prev
    );
        sram_pkg::sram_pins_t p;
        p       = prev;
        p.ce_n  = 1'b1;
        p.oe_n  = 1'b1;
        p.we_n  = 1'b1;
        p.be_n  = '1;
        p.drive = 1'b0;
        if (take) begin
            p.ce_n     = 1'b0;
            p.oe_n     = r.write;
            p.we_n     = !r.write;
            p.be_n     = r.write ? ~r.sel : '0;    // reads return all lanes
            p.addr     = a;
            p.data_out = r.wdata;
            p.drive    = r.write;
        end
        return p;
    endfunction

    assign cur_req = (slot == sram_pkg::SLOT_INST) ? inst_req : data_req;

    // the owner keeps valid high through its done cycle, so skip it there
    assign in_flight = done_q && done_owner == slot;
    assign grant     = cur_req.valid && !in_flight;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot       <= sram_pkg::SLOT_INST;
            busy       <= 1'b0;
            owner      <= sram_pkg::SLOT_INST;
            done_q     <= 1'b0;
            done_owner <= sram_pkg::SLOT_INST;
            base_q     <= idle_pins;
            ext_q      <= idle_pins;
        end else begin
            slot       <= (slot == sram_pkg::SLOT_INST) ? sram_pkg::SLOT_DATA
                                                        : sram_pkg::SLOT_INST;
            busy       <= grant;
            done_q     <= busy;
            done_owner <= owner;
            if (grant) begin
                owner <= slot;
            end
            base_q <= next_pins(grant && cur_req.base_en, cur_req, cur_req.base_addr, base_q);
            ext_q  <= next_pins(grant && cur_req.ext_en, cur_req, cur_req.ext_addr, ext_q);
        end
    end

    // chip outputs are valid at the end of the access cycle
    always_ff @(posedge clk) begin
        if (busy) begin
            base_rdata_q <= base_data_in;
            ext_rdata_q  <= ext_data_in;
        end
    end

    assign base_pins = base_q;
    assign ext_pins  = ext_q;

    assign inst_rsp = '{
        done:       done_q && (done_owner == sram_pkg::SLOT_INST),
        base_rdata: base_rdata_q,
        ext_rdata:  ext_rdata_q
    };
    assign data_rsp = '{
        done:       done_q && (done_owner == sram_pkg::SLOT_DATA),
        base_rdata: base_rdata_q,
        ext_rdata:  ext_rdata_q
    };

    no_bus_fight: assert property (@(posedge clk) disable iff (rst)
        (base_pins.oe_n || base_pins.we_n) && (ext_pins.oe_n || ext_pins.we_n))
        else $error("chip read and write enabled together");

    single_done: assert property (@(posedge clk) disable iff (rst)
        !(inst_rsp.done && data_rsp.done))
        else $error("done raised to both ports in one cycle");

    drive_on_write: assert property (@(posedge clk) disable iff (rst)
        (base_pins.drive -> !base_pins.we_n) && (ext_pins.drive -> !ext_pins.we_n))
        else $error("data bus driven outside a write");

endmodule

// File: verilog/sram_subsystem.sv
`timescale 1ns/1ps

module sram_subsystem (
    input  logic                 clk,
    input  logic                 rst,
    // instruction wishbone port
    input  logic                 ib_cyc,
    input  logic                 ib_stb,
    input  sram_pkg::bus_addr_t  ib_adr,
    output logic                 ib_ack,
    output sram_pkg::word_t      ib_dat,
    output sram_pkg::word_t      ib_dat2,
    // data wishbone port
    input  logic                 db_cyc,
    input  logic                 db_stb,
    input  logic                 db_we,
    input  sram_pkg::byte_sel_t  db_sel,
    input  sram_pkg::bus_addr_t  db_adr,
    input  sram_pkg::word_t      db_dat_w,
    output sram_pkg::word_t      db_dat_r,
    output logic                 db_ack,
    // chip pins
    output sram_pkg::sram_pins_t base_pins,
    input  sram_pkg::word_t      base_data_in,
    output sram_pkg::sram_pins_t ext_pins,
    input  sram_pkg::word_t      ext_data_in
);

    sram_pkg::sram_req_t inst_req;
    sram_pkg::sram_req_t data_req;
    sram_pkg::sram_rsp_t inst_rsp;
    sram_pkg::sram_rsp_t data_rsp;

    inst_fetch_port u_inst_port (
        .clk  (clk),
        .rst  (rst),
        .cyc  (ib_cyc),
        .stb  (ib_stb),
        .adr  (ib_adr),
        .rsp  (inst_rsp),
        .ack  (ib_ack),
        .dat  (ib_dat),
        .dat2 (ib_dat2),
        .req  (inst_req)
    );

    data_access_port u_data_port (
        .clk   (clk),
        .rst   (rst),
        .cyc   (db_cyc),
        .stb   (db_stb),
        .we    (db_we),
        .sel   (db_sel),
        .adr   (db_adr),
        .dat_w (db_dat_w),
        .rsp   (data_rsp),
        .ack   (db_ack),
        .dat_r (db_dat_r),
        .req   (data_req)
    );

    sram_bank_scheduler u_scheduler (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .data_req     (data_req),
        .inst_rsp     (inst_rsp),
        .data_rsp     (data_rsp),
        .base_data_in (base_data_in),
        .ext_data_in  (ext_data_in),
        .base_pins    (base_pins),
        .ext_pins     (ext_pins)
    );

endmodule

// File: verif/sram_chip_model.sv
`timescale 1ns/1ps
`include "sram_defs.svh"

module sram_chip_model (
    input  logic                 clk,
    input  sram_pkg::sram_pins_t pins,
    output sram_pkg::word_t      data
);

    sram_pkg::word_t mem [0:(1 << `SRAM_CHIP_AW) - 1];

    // asynchronous read, bus released to zero otherwise
    assign data = (!pins.ce_n && !pins.oe_n) ? mem[pins.addr] : '0;

    // the write lands at the edge that ends the access cycle
    always @(posedge clk) begin
        if (!pins.ce_n && !pins.we_n && pins.drive) begin
            for (int i = 0; i < `SRAM_SEL_W; i++) begin
                if (!pins.be_n[i]) begin    // byte enables are active low
                    mem[pins.addr][i*8 +: 8] <= pins.data_out[i*8 +: 8];
                end
            end
        end
    end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: verif/sram_subsystem_tb.sv
`timescale 1ns/1ps
`include "sram_defs.svh"

module sram_subsystem_tb;

    localparam int max_cycles = 2000;    // ~130 accesses at up to 6 cycles, plus gaps and reset
    localparam int ack_limit  = 8;       // cycles from request to ack before giving up

    logic                 clk;
    logic                 rst;
    logic                 ib_cyc;
    logic                 ib_stb;
    sram_pkg::bus_addr_t  ib_adr;
    logic                 ib_ack;
    sram_pkg::word_t      ib_dat;
    sram_pkg::word_t      ib_dat2;
    logic                 db_cyc;
    logic                 db_stb;
    logic                 db_we;
    sram_pkg::byte_sel_t  db_sel;
    sram_pkg::bus_addr_t  db_adr;
    sram_pkg::word_t      db_dat_w;
    sram_pkg::word_t      db_dat_r;
    logic                 db_ack;
    sram_pkg::sram_pins_t base_pins;
    sram_pkg::sram_pins_t ext_pins;
    sram_pkg::word_t      base_data_in;
    sram_pkg::word_t      ext_data_in;

    sram_pkg::word_t      ref_mem [sram_pkg::bus_addr_t];   // expected contents by word address
    sram_pkg::bus_addr_t  data_addrs [$];     // written words, top address bit set
    sram_pkg::bus_addr_t  fetch_addrs [$];    // fetch starts whose word pair is written
    integer               seed;
    int                   cycle_count = 0;
    int                   error_count = 0;

    tb_clock_gen u_clock (.clk(clk), .rst(rst));

    sram_subsystem DUT (
        .clk(clk), .rst(rst),
        .ib_cyc(ib_cyc), .ib_stb(ib_stb), .ib_adr(ib_adr),
        .ib_ack(ib_ack), .ib_dat(ib_dat), .ib_dat2(ib_dat2),
        .db_cyc(db_cyc), .db_stb(db_stb), .db_we(db_we), .db_sel(db_sel),
        .db_adr(db_adr), .db_dat_w(db_dat_w), .db_dat_r(db_dat_r), .db_ack(db_ack),
        .base_pins(base_pins), .base_data_in(base_data_in),
        .ext_pins(ext_pins), .ext_data_in(ext_data_in)
    );

    sram_chip_model u_base_chip (.clk(clk), .pins(base_pins), .data(base_data_in));
    sram_chip_model u_ext_chip (.clk(clk), .pins(ext_pins), .data(ext_data_in));

    task automatic abort_run();
        error_count++;
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic report_failure(input string what);
        $display("%0t %s", $time, what);
        abort_run();
    endtask

    // old word with the selected byte lanes replaced
    function automatic sram_pkg::word_t merge_lanes(input sram_pkg::word_t old_w,
            input sram_pkg::word_t new_w, input sram_pkg::byte_sel_t sel);
        sram_pkg::word_t w;
        w = old_w;
        for (int i = 0; i < `SRAM_SEL_W; i++) begin
            if (sel[i]) w[i*8 +: 8] = new_w[i*8 +: 8];
        end
        return w;
    endfunction

    function automatic sram_pkg::bus_addr_t random_addr(input logic region, input logic odd);
        sram_pkg::bus_addr_t a;
        a = sram_pkg::bus_addr_t'($random(seed));
        a[`SRAM_BUS_AW-1] = region;    // 1 for data traffic, 0 for fetch pairs
        a[`SRAM_BUS_AW-2] = 1'b0;      // adr+1 stays in the same region
        a[0] = odd;
        return a;
    endfunction

    // acceptance is one edge after the request, ack 3 or 4 cycles after that
    task automatic await_data_ack(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > ack_limit) report_failure({name, ": no ack from the data port"});
        end while (!db_ack);
        if (n - 2 < 3 || n - 2 > 4)
            report_failure($sformatf("%s: ack %0d cycles after acceptance", name, n - 2));
    endtask

    task automatic await_inst_ack();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > ack_limit) report_failure("fetch: no ack from the instruction port");
        end while (!ib_ack);
        if (n - 2 < 3 || n - 2 > 4)
            report_failure($sformatf("fetch: ack %0d cycles after acceptance", n - 2));
    endtask

    task automatic write_word(input sram_pkg::bus_addr_t adr, input sram_pkg::byte_sel_t sel,
                              input sram_pkg::word_t wdata);
        sram_pkg::word_t old_w;
        @(posedge clk);
        db_cyc   <= 1'b1;
        db_stb   <= 1'b1;
        db_we    <= 1'b1;
        db_sel   <= sel;
        db_adr   <= adr;
        db_dat_w <= wdata;
        await_data_ack("data write");
        old_w = ref_mem.exists(adr) ? ref_mem[adr] : '0;
        ref_mem[adr] = merge_lanes(old_w, wdata, sel);
    endtask

    task automatic read_word(input sram_pkg::bus_addr_t adr);
        @(posedge clk);
        db_cyc <= 1'b1;
        db_stb <= 1'b1;
        db_we  <= 1'b0;
        db_sel <= 4'hf;
        db_adr <= adr;
        await_data_ack("data read");
        check_value("db_dat_r", db_dat_r, ref_mem[adr]);
    endtask

    task automatic fetch_pair(input sram_pkg::bus_addr_t adr);
        @(posedge clk);
        ib_cyc <= 1'b1;
        ib_stb <= 1'b1;
        ib_adr <= adr;
        await_inst_ack();
        check_value("ib_dat", ib_dat, ref_mem[adr]);
        check_value("ib_dat2", ib_dat2, ref_mem[sram_pkg::bus_addr_t'(adr + 1)]);
    endtask

    // stb low for some cycles, no ack may show up meanwhile
    task automatic idle_data_bus(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            db_cyc <= 1'b0;
            db_stb <= 1'b0;
            @(negedge clk);
            if (db_ack) report_failure("data ack while stb was low");
        end
    endtask

    task automatic idle_inst_bus(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            ib_cyc <= 1'b0;
            ib_stb <= 1'b0;
            @(negedge clk);
            if (ib_ack) report_failure("instruction ack while stb was low");
        end
    endtask

    task automatic reset_outputs_idle();
        check_value("ib_ack", 32'(ib_ack), 32'd0);
        check_value("db_ack", 32'(db_ack), 32'd0);
        check_value("base_pins ce_n oe_n we_n drive", 32'({base_pins.ce_n, base_pins.oe_n,
                    base_pins.we_n, base_pins.drive}), 32'he);
        check_value("ext_pins ce_n oe_n we_n drive", 32'({ext_pins.ce_n, ext_pins.oe_n,
                    ext_pins.we_n, ext_pins.drive}), 32'he);
    endtask

    task automatic full_word_round_trip();
        sram_pkg::bus_addr_t a;
        for (int i = 0; i < 16; i++) begin
            a = random_addr(1'b1, i[0]);    // alternate base and ext bank
            data_addrs.push_back(a);
            write_word(a, 4'hf, $random(seed));
        end
        foreach (data_addrs[i]) read_word(data_addrs[i]);
        idle_data_bus(1);
    endtask

    task automatic byte_lane_writes();
        sram_pkg::byte_sel_t sels [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                          4'b0011, 4'b1100, 4'b0101, 4'b1010};
        sram_pkg::bus_addr_t a;
        foreach (sels[i]) begin
            a = random_addr(1'b1, i[0]);
            data_addrs.push_back(a);
            write_word(a, 4'hf, $random(seed));
            write_word(a, sels[i], $random(seed));
            read_word(a);
        end
        idle_data_bus(1);
    endtask

    task automatic paired_fetches();
        sram_pkg::bus_addr_t a;
        for (int i = 0; i < 6; i++) begin
            a = random_addr(1'b0, i[0]);
            write_word(a, 4'hf, $random(seed));
            write_word(sram_pkg::bus_addr_t'(a + 1), 4'hf, $random(seed));
            fetch_addrs.push_back(a);
        end
        idle_data_bus(1);
        foreach (fetch_addrs[i]) fetch_pair(fetch_addrs[i]);
        idle_inst_bus(1);
    endtask

    task automatic concurrent_traffic();
        sram_pkg::bus_addr_t fetch_list [20];
        sram_pkg::bus_addr_t data_list [20];
        sram_pkg::word_t     data_word [20];
        // picked up front so both masters run from a fixed sequence
        for (int i = 0; i < 20; i++) begin
            fetch_list[i] = fetch_addrs[$unsigned($random(seed)) % fetch_addrs.size()];
            if (i[0]) begin
                data_list[i] = data_addrs[$unsigned($random(seed)) % data_addrs.size()];
            end else begin
                data_list[i] = random_addr(1'b1, i[1]);
                data_addrs.push_back(data_list[i]);
            end
            data_word[i] = $random(seed);
        end
        fork
            begin
                for (int i = 0; i < 20; i++) fetch_pair(fetch_list[i]);
                idle_inst_bus(1);
            end
            begin
                for (int j = 0; j < 20; j++) begin
                    if (j[0]) read_word(data_list[j]);
                    else write_word(data_list[j], 4'hf, data_word[j]);
                end
                idle_data_bus(1);
            end
        join
    endtask

    task automatic stb_gap_restarts();
        sram_pkg::bus_addr_t a;
        for (int i = 0; i < 8; i++) begin
            a = data_addrs[$unsigned($random(seed)) % data_addrs.size()];
            if (i[0]) read_word(a);
            else write_word(a, sram_pkg::byte_sel_t'($random(seed)), $random(seed));
            idle_data_bus($unsigned($random(seed)) % 4);    // 0 keeps stb high into the next one
        end
        idle_data_bus(1);
        for (int i = 0; i < 6; i++) begin
            fetch_pair(fetch_addrs[$unsigned($random(seed)) % fetch_addrs.size()]);
            idle_inst_bus($unsigned($random(seed)) % 4);
        end
        idle_inst_bus(1);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: tests still running after %0d cycles", max_cycles);
            abort_run();
        end
    end

    initial begin
        seed     = 32'hcd85;
        ib_cyc   = 1'b0;
        ib_stb   = 1'b0;
        ib_adr   = '0;
        db_cyc   = 1'b0;
        db_stb   = 1'b0;
        db_we    = 1'b0;
        db_sel   = '0;
        db_adr   = '0;
        db_dat_w = '0;
        @(negedge rst);
        @(negedge clk);
        reset_outputs_idle();
        full_word_round_trip();
        byte_lane_writes();
        paired_fetches();
        concurrent_traffic();
        stb_gap_restarts();
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
verilog/sram_pkg.sv
verilog/inst_fetch_port.sv
verilog/data_access_port.sv
verilog/sram_bank_scheduler.sv
verilog/sram_subsystem.sv
verif/sram_chip_model.sv
verif/tb_clock_gen.sv
verif/sram_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module sram_subsystem_tb -f all.f --Mdir obj_dir

./obj_dir/Vsram_subsystem_tb 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"
